/* verilog/debug_pkg.sv */
package debug_pkg;

  // **************************************************************************
  // widths.
  // **************************************************************************
  localparam int unsigned CNT_W       = 48;
  localparam int unsigned LANE_W      = 12;
  localparam int unsigned NUM_LANES   = 16;
  localparam int unsigned WH_ADDR_W   = 14;
  localparam int unsigned FEAT_ADDR_W = 16;

  // **************************************************************************
  // stage handshakes, msb first.
  // **************************************************************************
  typedef struct packed {
    logic spmm_vld;
    logic spmm_rdy;
    logic dmvm_vld;
    logic dmvm_rdy;
    logic sm_vld;
    logic sm_rdy;
    logic aggr_vld;
    logic aggr_rdy;
  } stage_hs_t;

  typedef enum logic [1:0] {
    STG_SPMM = 2'd0,
    STG_DMVM = 2'd1,
    STG_SM   = 2'd2,
    STG_AGGR = 2'd3
  } stage_e;

  // word addresses on the wishbone port.
  typedef enum logic [3:0] {
    REG_ID          = 4'd0,
    REG_STATUS      = 4'd1,
    REG_CLEAR       = 4'd2,
    REG_CNT_SEL     = 4'd3,
    REG_CNT_LO      = 4'd4,
    REG_CNT_HI      = 4'd5,
    REG_SNAP_ADDR0  = 4'd6,
    REG_SNAP_ADDR1  = 4'd7,
    REG_SNAP_DATA0  = 4'd8,
    REG_SNAP_DATA1  = 4'd9,
    REG_WATCH_BOUND = 4'd10,
    REG_WATCH_ADDR  = 4'd11
  } dbg_reg_e;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic                   ena;
    logic [FEAT_ADDR_W-1:0] addr;
    logic [31:0]            din;
  } feat_wr_t;

  typedef struct packed {
    stage_e                 cnt_sel;
    logic [WH_ADDR_W-1:0]   snap_addr0;
    logic [WH_ADDR_W-1:0]   snap_addr1;
    logic [FEAT_ADDR_W-1:0] watch_bound;
  } dbg_cfg_t;

  typedef struct packed {
    logic [7:0] sticky;
    logic       watch;
    logic       cnt;
  } dbg_clr_t;

endpackage

/* verilog/hs_sticky_monitor.sv */
`timescale 1ns/10ps

module hs_sticky_monitor (
  input  logic                 clk,
  input  logic                 rst_n,
  input  debug_pkg::stage_hs_t hs_i,
  input  logic [7:0]           clr_mask_i,
  output debug_pkg::stage_hs_t sticky_o
);

  logic [7:0] sticky_q;
  logic [7:0] sticky_d;

  // a new pulse beats a clear of the same bit.
  always_comb begin
    sticky_d = (sticky_q & ~clr_mask_i) | hs_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sticky_q <= '0;
    end else begin
      sticky_q <= sticky_d;
    end
  end

  assign sticky_o = sticky_q;

endmodule

/* verilog/event_counter.sv */
`timescale 1ns/10ps

module event_counter (
  input  logic                        clk,
  input  logic                        rst_n,
  input  debug_pkg::stage_hs_t        hs_i,
  input  debug_pkg::stage_e           sel_i,
  input  logic                        clr_i,
  output logic [debug_pkg::CNT_W-1:0] count_o
);

  import debug_pkg::*;

  logic             vld_sel;
  logic [CNT_W-1:0] count_q;

  // valid of the chosen stage.
  always_comb begin
    case (sel_i)
      STG_SPMM: vld_sel = hs_i.spmm_vld;
      STG_DMVM: vld_sel = hs_i.dmvm_vld;
      STG_SM:   vld_sel = hs_i.sm_vld;
      STG_AGGR: vld_sel = hs_i.aggr_vld;
      default:  vld_sel = 1'b0;
    endcase
  end

  // wraps at the counter width.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (clr_i) begin
      count_q <= '0;
    end else if (vld_sel) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

endmodule

/* verilog/snapshot_capture.sv */
`timescale 1ns/10ps

module snapshot_capture #(
  parameter int unsigned SNAP_LANE = 2
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic [debug_pkg::NUM_LANES-1:0][debug_pkg::LANE_W-1:0] sppe_i,
  input  logic [debug_pkg::WH_ADDR_W-1:0]                        wh_addr_i,
  input  logic                                                   spmm_rdy_i,
  input  logic [debug_pkg::WH_ADDR_W-1:0]                        match_addr0_i,
  input  logic [debug_pkg::WH_ADDR_W-1:0]                        match_addr1_i,
  output logic [debug_pkg::LANE_W-1:0]                           snap0_o,
  output logic [debug_pkg::LANE_W-1:0]                           snap1_o
);

  import debug_pkg::*;

  logic [LANE_W-1:0]    lane_val;
  logic [WH_ADDR_W-1:0] match_addr [2];
  logic [LANE_W-1:0]    snap_q [2];

  assign lane_val      = sppe_i[SNAP_LANE];
  assign match_addr[0] = match_addr0_i;
  assign match_addr[1] = match_addr1_i;

  // **************************************************************************
  // capture slots.
  // **************************************************************************
  for (genvar k = 0; k < 2; k++) begin : g_slot
    logic hit;

    // only a ready spmm stage qualifies the address.
    assign hit = spmm_rdy_i && (wh_addr_i == match_addr[k]);

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        snap_q[k] <= '0;
      end else if (hit) begin
        snap_q[k] <= lane_val;
      end
    end
  end

  assign snap0_o = snap_q[0];
  assign snap1_o = snap_q[1];

endmodule

/* verilog/addr_watch.sv */
`timescale 1ns/10ps

module addr_watch (
  input  logic                              clk,
  input  logic                              rst_n,
  input  debug_pkg::feat_wr_t               feat_wr_i,
  input  logic [debug_pkg::FEAT_ADDR_W-1:0] bound_i,
  input  logic                              clr_i,
  output logic                              hit_o,
  output logic [debug_pkg::FEAT_ADDR_W-1:0] hit_addr_o
);

  import debug_pkg::*;

  logic                   over;
  logic                   hit_q;
  logic [FEAT_ADDR_W-1:0] addr_q;

  assign over = feat_wr_i.ena && (feat_wr_i.addr >= bound_i);

  // address latches on the first hit only.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hit_q  <= 1'b0;
      addr_q <= '0;
    end else if (clr_i) begin
      hit_q  <= 1'b0;
      addr_q <= '0;
    end else if (over && !hit_q) begin
      hit_q  <= 1'b1;
      addr_q <= feat_wr_i.addr;
    end
  end

  assign hit_o      = hit_q;
  assign hit_addr_o = addr_q;

endmodule

/* verilog/dbg_ctrl.sv */
`timescale 1ns/10ps

module dbg_ctrl #(
  parameter int unsigned                         NUM_SPARSE_DATA = 12,
  parameter logic [debug_pkg::FEAT_ADDR_W-1:0]   WATCH_BOUND_RST = 16'd43328
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  debug_pkg::wb_req_t                     wb_req_i,
  output debug_pkg::wb_rsp_t                     wb_rsp_o,
  output debug_pkg::dbg_cfg_t                    cfg_o,
  output debug_pkg::dbg_clr_t                    clr_o,
  input  debug_pkg::stage_hs_t                   sticky_i,
  input  logic [debug_pkg::CNT_W-1:0]            count_i,
  input  logic [debug_pkg::LANE_W-1:0]           snap0_i,
  input  logic [debug_pkg::LANE_W-1:0]           snap1_i,
  input  logic                                   watch_hit_i,
  input  logic [debug_pkg::FEAT_ADDR_W-1:0]      watch_addr_i
);

  import debug_pkg::*;

  typedef enum logic {
    IDLE,
    ACK
  } bus_state_e;

  bus_state_e  state_q;
  bus_state_e  state_d;
  dbg_cfg_t    cfg_q;
  dbg_reg_e    reg_sel;
  logic        ack;
  logic        wr_en;
  logic [31:0] rd_data;

  assign reg_sel = dbg_reg_e'(wb_req_i.adr);
  assign ack     = (state_q == ACK);
  // request fields are held by the master through the ack cycle.
  assign wr_en   = ack && wb_req_i.cyc && wb_req_i.stb && wb_req_i.we;

  // **************************************************************************
  // bus FSM, one ack cycle per access.
  // **************************************************************************
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (wb_req_i.cyc && wb_req_i.stb) begin
          state_d = ACK;
        end
      end
      ACK:     state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // configuration registers.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q.cnt_sel     <= STG_SPMM;
      cfg_q.snap_addr0  <= '0;
      cfg_q.snap_addr1  <= '0;
      cfg_q.watch_bound <= WATCH_BOUND_RST;
    end else if (wr_en) begin
      case (reg_sel)
        REG_CNT_SEL:     cfg_q.cnt_sel     <= stage_e'(wb_req_i.dat[1:0]);
        REG_SNAP_ADDR0:  cfg_q.snap_addr0  <= wb_req_i.dat[WH_ADDR_W-1:0];
        REG_SNAP_ADDR1:  cfg_q.snap_addr1  <= wb_req_i.dat[WH_ADDR_W-1:0];
        REG_WATCH_BOUND: cfg_q.watch_bound <= wb_req_i.dat[FEAT_ADDR_W-1:0];
        default: ;
      endcase
    end
  end

  // clear pulses last for the ack cycle only.
  always_comb begin
    clr_o = '0;
    if (wr_en && (reg_sel == REG_CLEAR)) begin
      clr_o.sticky = wb_req_i.dat[7:0];
      clr_o.watch  = wb_req_i.dat[8];
      clr_o.cnt    = wb_req_i.dat[9];
    end
  end

  // **************************************************************************
  // read data.
  // **************************************************************************
  always_comb begin
    case (reg_sel)
      REG_ID:          rd_data = 32'(NUM_SPARSE_DATA);
      REG_STATUS:      rd_data = {23'd0, watch_hit_i, sticky_i};
      REG_CNT_SEL:     rd_data = {30'd0, cfg_q.cnt_sel};
      REG_CNT_LO:      rd_data = count_i[31:0];
      REG_CNT_HI:      rd_data = 32'(count_i[CNT_W-1:32]);
      REG_SNAP_ADDR0:  rd_data = 32'(cfg_q.snap_addr0);
      REG_SNAP_ADDR1:  rd_data = 32'(cfg_q.snap_addr1);
      REG_SNAP_DATA0:  rd_data = 32'(snap0_i);
      REG_SNAP_DATA1:  rd_data = 32'(snap1_i);
      REG_WATCH_BOUND: rd_data = 32'(cfg_q.watch_bound);
      REG_WATCH_ADDR:  rd_data = 32'(watch_addr_i);
      default:         rd_data = '0;
    endcase
  end

  always_comb begin
    wb_rsp_o.ack = ack;
    wb_rsp_o.dat = rd_data;
  end

  assign cfg_o = cfg_q;

endmodule

/* verilog/debug_top.sv */
`timescale 1ns/10ps

module debug_top #(
  parameter int unsigned                       NUM_SPARSE_DATA = 12,
  parameter logic [debug_pkg::FEAT_ADDR_W-1:0] WATCH_BOUND_RST = 16'd43328,
  parameter int unsigned                       SNAP_LANE       = 2
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  debug_pkg::wb_req_t                                     wb_req_i,
  output debug_pkg::wb_rsp_t                                     wb_rsp_o,
  input  debug_pkg::stage_hs_t                                   stage_hs_i,
  input  logic [debug_pkg::NUM_LANES-1:0][debug_pkg::LANE_W-1:0] sppe_i,
  input  logic [debug_pkg::WH_ADDR_W-1:0]                        wh_addr_i,
  input  debug_pkg::feat_wr_t                                    feat_wr_i
);

  import debug_pkg::*;

  dbg_cfg_t               cfg;
  dbg_clr_t               clr;
  stage_hs_t              sticky;
  logic [CNT_W-1:0]       count;
  logic [LANE_W-1:0]      snap0;
  logic [LANE_W-1:0]      snap1;
  logic                   watch_hit;
  logic [FEAT_ADDR_W-1:0] watch_addr;

  // **************************************************************************
  // register port.
  // **************************************************************************
  dbg_ctrl #(
    .NUM_SPARSE_DATA (NUM_SPARSE_DATA),
    .WATCH_BOUND_RST (WATCH_BOUND_RST)
  ) i_dbg_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_req_i     (wb_req_i),
    .wb_rsp_o     (wb_rsp_o),
    .cfg_o        (cfg),
    .clr_o        (clr),
    .sticky_i     (sticky),
    .count_i      (count),
    .snap0_i      (snap0),
    .snap1_i      (snap1),
    .watch_hit_i  (watch_hit),
    .watch_addr_i (watch_addr)
  );

  // **************************************************************************
  // observers.
  // **************************************************************************
  hs_sticky_monitor i_hs_sticky_monitor (
    .clk        (clk),
    .rst_n      (rst_n),
    .hs_i       (stage_hs_i),
    .clr_mask_i (clr.sticky),
    .sticky_o   (sticky)
  );

  event_counter i_event_counter (
    .clk     (clk),
    .rst_n   (rst_n),
    .hs_i    (stage_hs_i),
    .sel_i   (cfg.cnt_sel),
    .clr_i   (clr.cnt),
    .count_o (count)
  );

  snapshot_capture #(
    .SNAP_LANE (SNAP_LANE)
  ) i_snapshot_capture (
    .clk           (clk),
    .rst_n         (rst_n),
    .sppe_i        (sppe_i),
    .wh_addr_i     (wh_addr_i),
    .spmm_rdy_i    (stage_hs_i.spmm_rdy),
    .match_addr0_i (cfg.snap_addr0),
    .match_addr1_i (cfg.snap_addr1),
    .snap0_o       (snap0),
    .snap1_o       (snap1)
  );

  addr_watch i_addr_watch (
    .clk        (clk),
    .rst_n      (rst_n),
    .feat_wr_i  (feat_wr_i),
    .bound_i    (cfg.watch_bound),
    .clr_i      (clr.watch),
    .hit_o      (watch_hit),
    .hit_addr_o (watch_addr)
  );

endmodule

/* testbench/tb_debug_top.sv */
`timescale 1ns/10ps

module tb_debug_top;

  import debug_pkg::*;

  localparam int unsigned            SNAP_LANE        = 2;
  localparam logic [31:0]            EXP_ID           = 32'd12;
  localparam logic [FEAT_ADDR_W-1:0] WATCH_BOUND_RST  = 16'd43328;
  localparam int                     PLANNED_ACCESSES = 56;

  // shadow of everything the register map exposes.
  typedef struct packed {
    dbg_cfg_t               cfg;
    logic                   ack;
    stage_hs_t              sticky;
    logic [CNT_W-1:0]       count;
    logic [LANE_W-1:0]      snap0;
    logic [LANE_W-1:0]      snap1;
    logic                   hit;
    logic [FEAT_ADDR_W-1:0] waddr;
  } model_t;

  typedef struct packed {
    dbg_reg_e         adr;
    logic [CNT_W-1:0] exp;
    logic [CNT_W-1:0] act;
  } rd_rec_t;

  logic                             clk;
  logic                             rst_n;
  wb_req_t                          wb_req;
  wb_rsp_t                          wb_rsp;
  stage_hs_t                        stage_hs;
  logic [NUM_LANES-1:0][LANE_W-1:0] sppe;
  logic [WH_ADDR_W-1:0]             wh_addr;
  feat_wr_t                         feat_wr;

  integer                 seed;
  int                     checks;
  int                     mismatches;
  int                     bus_errors;
  model_t                 m_q;
  rd_rec_t                rd_q[$];
  logic [WH_ADDR_W-1:0]   snap_a0;
  logic [WH_ADDR_W-1:0]   snap_a1;
  logic [FEAT_ADDR_W-1:0] bound_stim;

  debug_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_req_i   (wb_req),
    .wb_rsp_o   (wb_rsp),
    .stage_hs_i (stage_hs),
    .sppe_i     (sppe),
    .wh_addr_i  (wh_addr),
    .feat_wr_i  (feat_wr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  // **************************************************************************
  // reference model.
  // **************************************************************************
  function automatic model_t reset_model();
    model_t m;
    m = '0;
    m.cfg.watch_bound = WATCH_BOUND_RST;
    return m;
  endfunction

  function automatic model_t next_model(model_t m, wb_req_t req, stage_hs_t hs,
                                        logic [LANE_W-1:0] lane,
                                        logic [WH_ADDR_W-1:0] wh, feat_wr_t fw);
    model_t     n;
    dbg_reg_e   reg_sel;
    logic       wr;
    logic       vld;
    logic       clr_hit;
    logic       clr_watch;
    logic       clr_cnt;
    logic [7:0] clr_sticky;
    n          = m;
    reg_sel    = dbg_reg_e'(req.adr);
    wr         = m.ack && req.cyc && req.stb && req.we;
    clr_hit    = wr && (reg_sel == REG_CLEAR);
    clr_sticky = clr_hit ? req.dat[7:0] : 8'd0;
    clr_watch  = clr_hit && req.dat[8];
    clr_cnt    = clr_hit && req.dat[9];
    n.ack      = !m.ack && req.cyc && req.stb;
    if (wr) begin
      case (reg_sel)
        REG_CNT_SEL:     n.cfg.cnt_sel     = stage_e'(req.dat[1:0]);
        REG_SNAP_ADDR0:  n.cfg.snap_addr0  = req.dat[WH_ADDR_W-1:0];
        REG_SNAP_ADDR1:  n.cfg.snap_addr1  = req.dat[WH_ADDR_W-1:0];
        REG_WATCH_BOUND: n.cfg.watch_bound = req.dat[FEAT_ADDR_W-1:0];
        default: ;
      endcase
    end
    n.sticky = (m.sticky & ~clr_sticky) | hs;
    case (m.cfg.cnt_sel)
      STG_SPMM: vld = hs.spmm_vld;
      STG_DMVM: vld = hs.dmvm_vld;
      STG_SM:   vld = hs.sm_vld;
      STG_AGGR: vld = hs.aggr_vld;
      default:  vld = 1'b0;
    endcase
    if (clr_cnt) begin
      n.count = '0;
    end else if (vld) begin
      n.count = m.count + CNT_W'(1);
    end
    if (hs.spmm_rdy && (wh == m.cfg.snap_addr0)) begin
      n.snap0 = lane;
    end
    if (hs.spmm_rdy && (wh == m.cfg.snap_addr1)) begin
      n.snap1 = lane;
    end
    if (clr_watch) begin
      n.hit   = 1'b0;
      n.waddr = '0;
    end else if (fw.ena && (fw.addr >= m.cfg.watch_bound) && !m.hit) begin
      n.hit   = 1'b1;
      n.waddr = fw.addr;
    end
    return n;
  endfunction

  function automatic logic [31:0] expected_word(dbg_reg_e a, model_t m);
    case (a)
      REG_ID:          return EXP_ID;
      REG_STATUS:      return {23'd0, m.hit, m.sticky};
      REG_CNT_SEL:     return {30'd0, m.cfg.cnt_sel};
      REG_CNT_LO:      return m.count[31:0];
      REG_CNT_HI:      return {16'd0, m.count[CNT_W-1:32]};
      REG_SNAP_ADDR0:  return {18'd0, m.cfg.snap_addr0};
      REG_SNAP_ADDR1:  return {18'd0, m.cfg.snap_addr1};
      REG_SNAP_DATA0:  return {20'd0, m.snap0};
      REG_SNAP_DATA1:  return {20'd0, m.snap1};
      REG_WATCH_BOUND: return {16'd0, m.cfg.watch_bound};
      REG_WATCH_ADDR:  return {16'd0, m.waddr};
      default:         return 32'd0;
    endcase
  endfunction

  // steps on the same edges as the DUT flops.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_q <= reset_model();
    end else begin
      m_q <= next_model(m_q, wb_req, stage_hs, sppe[SNAP_LANE], wh_addr, feat_wr);
    end
  end

  // **************************************************************************
  // compare tasks.
  // **************************************************************************
  task automatic check_hs(input string name, input stage_hs_t exp, input stage_hs_t act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_cnt(input string name, input logic [CNT_W-1:0] exp,
                           input logic [CNT_W-1:0] act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  always @(negedge clk) begin : compare_reads
    rd_rec_t r;
    check_word("wb_rsp_o.ack", 32'(m_q.ack), 32'(wb_rsp.ack));
    while (rd_q.size() > 0) begin
      r = rd_q.pop_front();
      case (r.adr)
        REG_STATUS: begin
          check_hs("REG_STATUS[7:0]", r.exp[7:0], r.act[7:0]);
          check_word("REG_STATUS[31:8]", {8'd0, r.exp[31:8]}, {8'd0, r.act[31:8]});
        end
        REG_CNT_LO: check_cnt("REG_CNT_HI:REG_CNT_LO", r.exp, r.act);
        default:    check_word(r.adr.name(), r.exp[31:0], r.act[31:0]);
      endcase
    end
  end

  // **************************************************************************
  // bus and stimulus tasks.
  // **************************************************************************
  task automatic wb_access(input dbg_reg_e adr, input logic we, input logic [31:0] wdat,
                           output logic [31:0] rdat, output model_t m_ack);
    wb_req_t req;
    int      waited;
    logic    got;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = wdat;
    got     = 1'b0;
    waited  = 0;
    rdat    = '0;
    m_ack   = m_q;
    @(posedge clk);
    wb_req <= req;
    while (!got && (waited < 8)) begin
      @(negedge clk);
      waited++;
      if (wb_rsp.ack) begin
        got   = 1'b1;
        rdat  = wb_rsp.dat;
        m_ack = m_q;
      end
    end
    // request stays up until the edge that ends the ack cycle.
    @(posedge clk);
    wb_req <= '0;
    if (!got) begin
      bus_errors++;
      $display("no ack from the DUT within %0d cycles for %s", waited, adr.name());
    end
  endtask

  task automatic wb_write(input dbg_reg_e adr, input logic [31:0] wdat);
    logic [31:0] rdat;
    model_t      m;
    wb_access(adr, 1'b1, wdat, rdat, m);
  endtask

  task automatic read_reg(input dbg_reg_e adr);
    logic [31:0] act;
    model_t      m;
    rd_rec_t     r;
    wb_access(adr, 1'b0, 32'd0, act, m);
    r.adr = adr;
    r.exp = CNT_W'(expected_word(adr, m));
    r.act = CNT_W'(act);
    rd_q.push_back(r);
  endtask

  // the count is only read while the valids are idle.
  task automatic read_count();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] exp_lo;
    logic [31:0] exp_hi;
    model_t      m_lo;
    model_t      m_hi;
    rd_rec_t     r;
    wb_access(REG_CNT_LO, 1'b0, 32'd0, lo, m_lo);
    wb_access(REG_CNT_HI, 1'b0, 32'd0, hi, m_hi);
    exp_lo = expected_word(REG_CNT_LO, m_lo);
    exp_hi = expected_word(REG_CNT_HI, m_hi);
    r.adr  = REG_CNT_LO;
    r.exp  = {exp_hi[15:0], exp_lo};
    r.act  = {hi[15:0], lo};
    rd_q.push_back(r);
    // whole high word, upper half reads as zero.
    r.adr  = REG_CNT_HI;
    r.exp  = CNT_W'(exp_hi);
    r.act  = CNT_W'(hi);
    rd_q.push_back(r);
  endtask

  task automatic drive_random(input int cycles);
    logic [NUM_LANES-1:0][LANE_W-1:0] lanes;
    logic [31:0]                      rnd;
    logic [WH_ADDR_W-1:0]             wh;
    feat_wr_t                         fw;
    for (int c = 0; c < cycles; c++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        rnd      = rand32();
        lanes[l] = rnd[LANE_W-1:0];
      end
      rnd = rand32();
      case (rnd[1:0])
        2'd0:    wh = snap_a0;
        2'd1:    wh = snap_a1;
        default: wh = rnd[WH_ADDR_W+1:2];
      endcase
      rnd     = rand32();
      fw.ena  = rnd[0];
      fw.din  = rand32();
      // half of the writes land close to the bound.
      if (rnd[1]) begin
        fw.addr = rnd[31:16];
      end else begin
        fw.addr = bound_stim - 16'd4 + {13'd0, rnd[4:2]};
      end
      rnd = rand32();
      @(posedge clk);
      stage_hs <= rnd[7:0];
      sppe     <= lanes;
      wh_addr  <= wh;
      feat_wr  <= fw;
    end
  endtask

  task automatic go_idle();
    @(posedge clk);
    stage_hs <= '0;
    wh_addr  <= '0;
    feat_wr  <= '0;
  endtask

  // **************************************************************************
  // test sequence.
  // **************************************************************************
  initial begin : main_seq
    logic [31:0] rnd;
    seed       = 32'h917c;
    checks     = 0;
    mismatches = 0;
    bus_errors = 0;
    rst_n      = 1'b0;
    wb_req     = '0;
    stage_hs   = '0;
    sppe       = '0;
    wh_addr    = '0;
    feat_wr    = '0;
    snap_a0    = '0;
    snap_a1    = '0;
    bound_stim = WATCH_BOUND_RST;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // reset values, ack stays low with no request.
    repeat (3) begin
      @(negedge clk);
      if (wb_rsp.ack !== 1'b0) begin
        bus_errors++;
        $display("ack is high while the bus is idle");
      end
    end
    read_reg(REG_ID);
    read_reg(REG_STATUS);
    read_count();
    read_reg(REG_WATCH_BOUND);
    read_reg(REG_CLEAR);

    // sticky flags and masked clears.
    repeat (3) begin
      drive_random(24);
      go_idle();
      read_reg(REG_STATUS);
      rnd = rand32();
      wb_write(REG_CLEAR, {24'd0, rnd[7:0]});
      read_reg(REG_STATUS);
    end
    fork
      wb_write(REG_CLEAR, 32'h0000_00ff);
      begin
        @(posedge clk);
        stage_hs <= 8'ha5;
        repeat (2) @(posedge clk);
        stage_hs <= '0;
      end
    join
    read_reg(REG_STATUS);

    // valid counter for each stage.
    for (int s = 0; s < 4; s++) begin
      wb_write(REG_CNT_SEL, 32'(s));
      read_reg(REG_CNT_SEL);
      wb_write(REG_CLEAR, 32'h0000_0200);
      drive_random(60);
      go_idle();
      read_count();
    end
    wb_write(REG_CLEAR, 32'h0000_0200);
    read_count();

    // snapshot slots.
    rnd     = rand32();
    snap_a0 = rnd[13:0];
    snap_a1 = rnd[29:16];
    wb_write(REG_SNAP_ADDR0, 32'(snap_a0));
    wb_write(REG_SNAP_ADDR1, 32'(snap_a1));
    read_reg(REG_SNAP_ADDR0);
    read_reg(REG_SNAP_ADDR1);
    drive_random(200);
    go_idle();
    read_reg(REG_SNAP_DATA0);
    read_reg(REG_SNAP_DATA1);

    // feature write bound.
    rnd        = rand32();
    bound_stim = {2'b10, rnd[13:0]};
    wb_write(REG_WATCH_BOUND, 32'(bound_stim));
    wb_write(REG_CLEAR, 32'h0000_0100);
    read_reg(REG_STATUS);
    read_reg(REG_WATCH_ADDR);
    drive_random(150);
    go_idle();
    read_reg(REG_STATUS);
    read_reg(REG_WATCH_ADDR);
    read_reg(REG_WATCH_BOUND);
    wb_write(REG_CLEAR, 32'h0000_0100);
    drive_random(150);
    go_idle();
    read_reg(REG_STATUS);
    read_reg(REG_WATCH_ADDR);

    repeat (3) @(posedge clk);
    $display("checks %0d, mismatches %0d, bus errors %0d", checks, mismatches, bus_errors);
    if ((mismatches == 0) && (bus_errors == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (40 * PLANNED_ACCESSES + 2000) @(posedge clk);
    $display("watchdog expired before the test sequence finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* flist.f */
verilog/debug_pkg.sv
verilog/hs_sticky_monitor.sv
verilog/event_counter.sv
verilog/snapshot_capture.sv
verilog/addr_watch.sv
verilog/dbg_ctrl.sv
verilog/debug_top.sv
testbench/tb_debug_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_debug_top -f flist.f \
  -o tb_debug_top > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_debug_top > sim.log 2>&1 \
  || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
